/* sim.f */
ica_pkg.sv
whiten_coef_bank.sv
whiten_matrix_mult.sv
whiten_sample_counter.sv
whiten_ctrl_fsm.sv
ica_whitening_top.sv
tb_ica_whitening_sva.sv
tb_ica_whitening.sv

/* Makefile */
# Verilator build and run of the whitening testbench.
TOOL   := verilator
FLAGS  := --binary --timing --assert -Wno-fatal -j 0
TOP    := tb_ica_whitening
FLIST  := sim.f
OBJDIR := obj_dir

SRCS   := $(shell grep -v '^+' $(FLIST))
BIN    := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

# fails unless the pass line shows up in the output.
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)

/* tb_ica_whitening.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ica_whitening;
    import ica_pkg::*;

    // per test sample counts that size the watchdog.
    localparam int n_identity    = 6;
    localparam int n_random      = 24;
    localparam int n_saturation  = 6;
    localparam int n_shadow      = 8;
    localparam int n_control     = 10;
    localparam int total_samples = n_identity + n_random + n_saturation + 2 * n_shadow + n_control;
    localparam longint timeout_ns = (total_samples * 20 + 1000) * 10;

    logic                     clk;
    logic                     reset;
    logic                     coef_wr;
    logic        [idx_w-1:0]  coef_idx;
    logic signed [data_w-1:0] coef_data;
    logic                     start;
    logic        [len_w-1:0]  block_len;
    logic                     x_valid;
    logic signed [data_w-1:0] x0, x1, x2, x3;
    logic                     z_valid;
    logic signed [data_w-1:0] z0, z1, z2, z3;
    logic                     busy;
    logic                     done;

    logic signed [data_w-1:0] shadow_m [num_ch*num_ch];  // host view of the shadow bank.
    logic signed [data_w-1:0] active_m [num_ch*num_ch];  // matrix of the open block.
    logic [4*data_w:0]        exp_q [$];                 // {last, z3, z2, z1, z0}.
    int                       exp_cyc_q [$];
    int unsigned              rng_state = 32;
    int                       cycle = 0;
    int                       remaining = 0;             // samples the open block still takes.
    int                       error_count = 0;
    int                       check_count = 0;
    int                       test_count = 0;
    int                       done_count = 0;
    logic                     done_prev = 1'b0;

    ica_whitening_top ica_whitening_top_inst (
        .clk       (clk),
        .reset     (reset),
        .coef_wr   (coef_wr),
        .coef_idx  (coef_idx),
        .coef_data (coef_data),
        .start     (start),
        .block_len (block_len),
        .x_valid   (x_valid),
        .x0        (x0),
        .x1        (x1),
        .x2        (x2),
        .x3        (x3),
        .z_valid   (z_valid),
        .z0        (z0),
        .z1        (z1),
        .z2        (z2),
        .z3        (z3),
        .busy      (busy),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ************************************************************************
    // stimulus helpers and reference model.
    // ************************************************************************

    function automatic int unsigned lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // random value of the given signed width.
    function automatic logic signed [data_w-1:0] rand_signed(input int bits);
        int r;
        r = int'(lcg_next() >> 4);
        r = (r <<< (32 - bits)) >>> (32 - bits);
        return data_w'(r);
    endfunction

    function automatic logic signed [data_w-1:0] model_row(
        input int                       row,
        input logic signed [data_w-1:0] xa,
        input logic signed [data_w-1:0] xb,
        input logic signed [data_w-1:0] xc,
        input logic signed [data_w-1:0] xd
    );
        logic signed [acc_w-1:0] xs [num_ch];
        logic signed [acc_w-1:0] coef;
        logic signed [acc_w-1:0] sum;
        logic signed [acc_w-1:0] q;
        xs[0] = xa;
        xs[1] = xb;
        xs[2] = xc;
        xs[3] = xd;
        sum = '0;
        for (int c = 0; c < num_ch; c++) begin
            coef = active_m[row*num_ch+c];
            sum  = sum + coef * xs[c];
        end
        q = sum >>> frac_w;  // floor of the q13 scaling.
        if (q > z_max) begin
            return z_max;
        end
        if (q < z_min) begin
            return z_min;
        end
        return q[data_w-1:0];
    endfunction

    task automatic check_z(input string name, input logic signed [data_w-1:0] got,
                           input logic signed [data_w-1:0] want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("ERROR %s got %h expected %h at cycle %0d", name, got, want, cycle);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("ERROR %s got %h expected %h at cycle %0d", name, got, want, cycle);
        end
    endtask

    // the tasks below start and end on a falling edge.
    task automatic set_write(input int idx, input logic signed [data_w-1:0] value);
        coef_wr       = 1'b1;
        coef_idx      = idx_w'(idx);
        coef_data     = value;
        shadow_m[idx] = value;
    endtask

    task automatic write_coef(input int idx, input logic signed [data_w-1:0] value);
        set_write(idx, value);
        @(negedge clk);
        coef_wr = 1'b0;
    endtask

    task automatic send_sample(
        input logic signed [data_w-1:0] xa,
        input logic signed [data_w-1:0] xb,
        input logic signed [data_w-1:0] xc,
        input logic signed [data_w-1:0] xd
    );
        logic signed [data_w-1:0] e [num_ch];
        x_valid = 1'b1;
        x0 = xa;
        x1 = xb;
        x2 = xc;
        x3 = xd;
        if (remaining > 0) begin
            for (int r = 0; r < num_ch; r++) begin
                e[r] = model_row(r, xa, xb, xc, xd);
            end
            exp_q.push_back({(remaining == 1), e[3], e[2], e[1], e[0]});
            exp_cyc_q.push_back(cycle + 2);  // two stage pipeline.
            remaining--;
        end
        @(negedge clk);
        x_valid = 1'b0;
    endtask

    task automatic send_random_sample(input int bits);
        send_sample(rand_signed(bits), rand_signed(bits), rand_signed(bits), rand_signed(bits));
    endtask

    task automatic start_block(input int len, input logic accept, input logic busy_want);
        start     = 1'b1;
        block_len = len_w'(len);
        if (accept) begin
            for (int i = 0; i < num_ch * num_ch; i++) begin
                active_m[i] = shadow_m[i];
            end
            remaining = len;
        end
        @(negedge clk);
        start = 1'b0;
        check_flag("busy", busy, busy_want);
    endtask

    // returns on the first falling edge with no block open.
    task automatic wait_block_end();
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task automatic load_random(input int bits);
        for (int i = 0; i < num_ch * num_ch; i++) begin
            write_coef(i, rand_signed(bits));
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        test_count++;
        if (error_count == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - err_before);
        end
    endtask

    // ************************************************************************
    // result monitor.
    // ************************************************************************

    always @(negedge clk) begin
        logic [4*data_w:0] entry;
        int                due;
        if (!reset) begin
            if (done_prev) begin
                check_flag("busy", busy, 1'b0);
            end
            if (z_valid && exp_q.size() == 0) begin
                error_count++;
                $display("z_valid at cycle %0d with no sample pending", cycle);
                check_flag("done", done, 1'b0);
            end else if (z_valid) begin
                entry = exp_q.pop_front();
                due   = exp_cyc_q.pop_front();
                if (due != cycle) begin
                    error_count++;
                    $display("result arrived at cycle %0d but was due at cycle %0d", cycle, due);
                end
                check_z("z0", z0, entry[data_w-1:0]);
                check_z("z1", z1, entry[2*data_w-1:data_w]);
                check_z("z2", z2, entry[3*data_w-1:2*data_w]);
                check_z("z3", z3, entry[4*data_w-1:3*data_w]);
                check_flag("done", done, entry[4*data_w]);
            end else begin
                check_flag("done", done, 1'b0);
            end
            if (done) begin
                done_count++;
            end
            done_prev = done;
        end
    end

    // ************************************************************************
    // directed tests.
    // ************************************************************************

    task automatic test_identity();
        int err0;
        err0 = error_count;
        for (int i = 0; i < num_ch * num_ch; i++) begin
            write_coef(i, (i % 5 == 0) ? data_w'(8192) : data_w'(0));  // 1.0 on the diagonal.
        end
        start_block(n_identity, 1'b1, 1'b1);
        repeat (n_identity) send_random_sample(data_w);
        wait_block_end();
        finish_test("identity", err0);
    endtask

    task automatic test_random();
        int err0;
        err0 = error_count;
        load_random(16);
        start_block(n_random, 1'b1, 1'b1);
        repeat (n_random) send_random_sample(20);  // back to back.
        wait_block_end();
        finish_test("random", err0);
    endtask

    task automatic test_saturation();
        int err0;
        err0 = error_count;
        for (int i = 0; i < num_ch * num_ch; i++) begin
            case (i)
                0, 1, 2, 3:     write_coef(i, z_max);
                4, 5, 6, 7:     write_coef(i, z_min);
                8:              write_coef(i, data_w'(1));
                12:             write_coef(i, -data_w'(1));
                default:        write_coef(i, '0);
            endcase
        end
        start_block(n_saturation, 1'b1, 1'b1);
        send_sample(z_max, z_max, z_max, z_max);
        send_sample(z_min, z_min, z_min, z_min);
        send_sample(-data_w'(5), data_w'(1), data_w'(1), data_w'(1));
        send_sample(data_w'(5), '0, '0, '0);
        send_sample(-data_w'(8193), '0, '0, '0);
        send_sample(z_max, z_min, z_max, z_min);
        wait_block_end();
        finish_test("saturation", err0);
    endtask

    task automatic test_shadow_update();
        int err0;
        err0 = error_count;
        load_random(14);
        start_block(n_shadow, 1'b1, 1'b1);
        for (int i = 0; i < n_shadow; i++) begin
            set_write(i, rand_signed(16));  // new matrix lands in the shadow only.
            send_random_sample(20);
            coef_wr = 1'b0;
        end
        for (int i = n_shadow; i < num_ch * num_ch; i++) begin
            write_coef(i, rand_signed(16));
        end
        wait_block_end();
        start_block(n_shadow, 1'b1, 1'b1);
        repeat (n_shadow) send_random_sample(20);
        wait_block_end();
        finish_test("shadow_update", err0);
    endtask

    task automatic test_block_control();
        int err0;
        int done0;
        err0  = error_count;
        done0 = done_count;
        repeat (3) send_random_sample(20);       // dropped while idle.
        start_block(0, 1'b0, 1'b0);
        send_random_sample(20);
        start_block(4, 1'b1, 1'b1);
        repeat (2) send_random_sample(20);
        start_block(9, 1'b0, 1'b1);              // ignored while busy.
        repeat (2) send_random_sample(20);
        wait_block_end();
        repeat (2) send_random_sample(20);
        repeat (4) @(negedge clk);
        if (done_count - done0 != 1) begin
            error_count++;
            $display("done pulsed %0d times for a single block", done_count - done0);
        end
        finish_test("block_control", err0);
    endtask

    initial begin
        reset     = 1'b1;
        coef_wr   = 1'b0;
        coef_idx  = '0;
        coef_data = '0;
        start     = 1'b0;
        block_len = '0;
        x_valid   = 1'b0;
        x0        = '0;
        x1        = '0;
        x2        = '0;
        x3        = '0;
        for (int i = 0; i < num_ch * num_ch; i++) begin
            shadow_m[i] = '0;
            active_m[i] = '0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("z_valid", z_valid, 1'b0);

        test_identity();
        test_random();
        test_saturation();
        test_shadow_update();
        test_block_control();

        if (exp_q.size() != 0) begin
            error_count++;
            $display("%0d expected results never arrived", exp_q.size());
        end
        $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog.
    initial begin
        #(timeout_ns);
        $display("timeout: the tests did not finish within %0d ns", timeout_ns);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_ica_whitening_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module ica_whitening_sva (
    input logic clk,
    input logic reset,
    input logic sample_en,
    input logic z_valid,
    input logic busy,
    input logic done
);

    // ************************************************************************
    // block handshakes.
    // ************************************************************************

    // done closes a block that was open and comes with its last result.
    done_in_block: assert property (@(posedge clk) disable iff (reset)
        done |-> z_valid && $past(busy))
        else $error("done high outside a block or without its last result");

    busy_after_done: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
        else $error("busy still high the cycle after done");

    // fixed latency of the multiplier.
    sample_to_result: assert property (@(posedge clk) disable iff (reset)
        sample_en |-> ##2 z_valid)
        else $error("no z_valid two cycles after an accepted sample");

    result_from_sample: assert property (@(posedge clk) disable iff (reset)
        z_valid |-> $past(sample_en, 2))
        else $error("z_valid without an accepted sample two cycles before");

endmodule

bind ica_whitening_top ica_whitening_sva ica_whitening_sva_inst (
    .clk       (clk),
    .reset     (reset),
    .sample_en (sample_en),
    .z_valid   (z_valid),
    .busy      (busy),
    .done      (done)
);

`default_nettype wire

/* ica_whitening_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ica_whitening_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               coef_wr,
    input  logic        [ica_pkg::idx_w-1:0]   coef_idx,
    input  logic signed [ica_pkg::data_w-1:0]  coef_data,
    input  logic                               start,
    input  logic        [ica_pkg::len_w-1:0]   block_len,
    input  logic                               x_valid,
    input  logic signed [ica_pkg::data_w-1:0]  x0, x1, x2, x3,
    output logic                               z_valid,
    output logic signed [ica_pkg::data_w-1:0]  z0, z1, z2, z3,
    output logic                               busy,
    output logic                               done
);
    import ica_pkg::*;

    logic                     coef_commit;
    logic                     counter_load;
    logic                     sample_en;
    logic                     last_sample;
    logic                     drain_done;
    logic signed [data_w-1:0] v [num_ch*num_ch];  // active matrix, row major.

    // ************************************************************************
    // control.
    // ************************************************************************

    whiten_ctrl_fsm whiten_ctrl_fsm_inst (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .block_len    (block_len),
        .x_valid      (x_valid),
        .last_sample  (last_sample),
        .drain_done   (drain_done),
        .coef_commit  (coef_commit),
        .counter_load (counter_load),
        .sample_en    (sample_en),
        .busy         (busy),
        .done         (done)
    );

    whiten_sample_counter whiten_sample_counter_inst (
        .clk         (clk),
        .reset       (reset),
        .load        (counter_load),
        .block_len   (block_len),
        .sample_en   (sample_en),
        .last_sample (last_sample),
        .drain_done  (drain_done)
    );

    // ************************************************************************
    // datapath.
    // ************************************************************************

    whiten_coef_bank whiten_coef_bank_inst (
        .clk         (clk),
        .reset       (reset),
        .coef_wr     (coef_wr),
        .coef_commit (coef_commit),
        .coef_idx    (coef_idx),
        .coef_data   (coef_data),
        .v00 (v[0]),  .v01 (v[1]),  .v02 (v[2]),  .v03 (v[3]),
        .v10 (v[4]),  .v11 (v[5]),  .v12 (v[6]),  .v13 (v[7]),
        .v20 (v[8]),  .v21 (v[9]),  .v22 (v[10]), .v23 (v[11]),
        .v30 (v[12]), .v31 (v[13]), .v32 (v[14]), .v33 (v[15])
    );

    whiten_matrix_mult whiten_matrix_mult_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (sample_en),
        .x0        (x0),
        .x1        (x1),
        .x2        (x2),
        .x3        (x3),
        .v00 (v[0]),  .v01 (v[1]),  .v02 (v[2]),  .v03 (v[3]),
        .v10 (v[4]),  .v11 (v[5]),  .v12 (v[6]),  .v13 (v[7]),
        .v20 (v[8]),  .v21 (v[9]),  .v22 (v[10]), .v23 (v[11]),
        .v30 (v[12]), .v31 (v[13]), .v32 (v[14]), .v33 (v[15]),
        .out_valid (z_valid),
        .z0        (z0),
        .z1        (z1),
        .z2        (z2),
        .z3        (z3)
    );

endmodule

`default_nettype wire

/* whiten_ctrl_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module whiten_ctrl_fsm (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic [ica_pkg::len_w-1:0]   block_len,
    input  logic                        x_valid,
    input  logic                        last_sample,
    input  logic                        drain_done,
    output logic                        coef_commit,
    output logic                        counter_load,
    output logic                        sample_en,
    output logic                        busy,
    output logic                        done
);
    import ica_pkg::*;

    logic [state_w-1:0] state;
    logic [state_w-1:0] state_next;
    logic               accept;  // start taken this cycle.

    // a zero length block is never opened.
    assign accept = (state == st_idle) && start && (block_len != '0);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    state_next = st_run;
                end
            end
            st_run: begin
                if (last_sample) begin
                    state_next = st_drain;
                end
            end
            st_drain: begin
                if (drain_done) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // ************************************************************************
    // outputs.
    // ************************************************************************

    assign coef_commit  = accept;                          // matrix fixed for the block.
    assign counter_load = accept;
    assign sample_en    = x_valid && (state == st_run);   // drop samples outside a block.
    assign busy         = (state != st_idle);
    assign done         = (state == st_drain) && drain_done;

endmodule

`default_nettype wire

/* whiten_sample_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module whiten_sample_counter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        load,
    input  logic [ica_pkg::len_w-1:0]   block_len,
    input  logic                        sample_en,
    output logic                        last_sample,
    output logic                        drain_done
);
    import ica_pkg::*;

    localparam int drain_w = $clog2(drain_cycles + 1);

    logic [len_w-1:0]   len_reg;
    logic [len_w-1:0]   count;
    logic [len_w-1:0]   count_next;
    logic [drain_w-1:0] drain_timer;  // cycles until the last result leaves.

    assign count_next  = count + 1'b1;
    assign last_sample = sample_en && (count_next == len_reg);

    always_ff @(posedge clk) begin
        if (reset) begin
            len_reg <= '0;
            count   <= '0;
        end else if (load) begin
            len_reg <= block_len;
            count   <= '0;
        end else if (sample_en) begin
            count <= count_next;
        end
    end

    // the timer tracks the pipeline depth after the final sample.
    always_ff @(posedge clk) begin
        if (reset) begin
            drain_timer <= '0;
        end else if (last_sample) begin
            drain_timer <= drain_w'(drain_cycles);
        end else if (drain_timer != '0) begin
            drain_timer <= drain_timer - 1'b1;
        end
    end

    assign drain_done = (drain_timer == drain_w'(1));  // lines up with the last z_valid.

endmodule

`default_nettype wire

/* whiten_matrix_mult.sv */
`timescale 1ns/10ps
`default_nettype none

module whiten_matrix_mult (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               in_valid,
    input  logic signed [ica_pkg::data_w-1:0]  x0, x1, x2, x3,
    input  logic signed [ica_pkg::data_w-1:0]  v00, v01, v02, v03,
    input  logic signed [ica_pkg::data_w-1:0]  v10, v11, v12, v13,
    input  logic signed [ica_pkg::data_w-1:0]  v20, v21, v22, v23,
    input  logic signed [ica_pkg::data_w-1:0]  v30, v31, v32, v33,
    output logic                               out_valid,
    output logic signed [ica_pkg::data_w-1:0]  z0, z1, z2, z3
);
    import ica_pkg::*;

    logic signed [data_w-1:0] x         [num_ch];
    logic signed [data_w-1:0] v         [num_ch*num_ch];
    logic signed [prod_w-1:0] prod      [num_ch*num_ch];  // stage one products.
    logic                     prod_valid;
    logic signed [acc_w-1:0]  row_sum   [num_ch];
    logic signed [acc_w-1:0]  row_shift [num_ch];
    logic signed [data_w-1:0] row_sat   [num_ch];
    logic signed [data_w-1:0] z_reg     [num_ch];         // stage two results.

    assign x[0] = x0;
    assign x[1] = x1;
    assign x[2] = x2;
    assign x[3] = x3;

    assign v[0]  = v00;
    assign v[1]  = v01;
    assign v[2]  = v02;
    assign v[3]  = v03;
    assign v[4]  = v10;
    assign v[5]  = v11;
    assign v[6]  = v12;
    assign v[7]  = v13;
    assign v[8]  = v20;
    assign v[9]  = v21;
    assign v[10] = v22;
    assign v[11] = v23;
    assign v[12] = v30;
    assign v[13] = v31;
    assign v[14] = v32;
    assign v[15] = v33;

    // ************************************************************************
    // stage one, sixteen products.
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int r = 0; r < num_ch; r++) begin
                for (int c = 0; c < num_ch; c++) begin
                    prod[r*num_ch+c] <= v[r*num_ch+c] * x[c];  // full 52 bit product.
                end
            end
        end
    end

    // ************************************************************************
    // stage two, row sums, q13 shift and clamp.
    // ************************************************************************

    always_comb begin
        for (int r = 0; r < num_ch; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < num_ch; c++) begin
                row_sum[r] = row_sum[r] + prod[r*num_ch+c];
            end
            row_shift[r] = row_sum[r] >>> frac_w;  // floor, toward minus infinity.
            if (row_shift[r] > z_max) begin
                row_sat[r] = z_max;
            end else if (row_shift[r] < z_min) begin
                row_sat[r] = z_min;
            end else begin
                row_sat[r] = row_shift[r][data_w-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= prod_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            for (int r = 0; r < num_ch; r++) begin
                z_reg[r] <= row_sat[r];
            end
        end
    end

    assign z0 = z_reg[0];
    assign z1 = z_reg[1];
    assign z2 = z_reg[2];
    assign z3 = z_reg[3];

endmodule

`default_nettype wire

/* whiten_coef_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module whiten_coef_bank (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               coef_wr,
    input  logic                               coef_commit,
    input  logic        [ica_pkg::idx_w-1:0]   coef_idx,
    input  logic signed [ica_pkg::data_w-1:0]  coef_data,
    output logic signed [ica_pkg::data_w-1:0]  v00, v01, v02, v03,
    output logic signed [ica_pkg::data_w-1:0]  v10, v11, v12, v13,
    output logic signed [ica_pkg::data_w-1:0]  v20, v21, v22, v23,
    output logic signed [ica_pkg::data_w-1:0]  v30, v31, v32, v33
);
    import ica_pkg::*;

    logic signed [data_w-1:0] shadow [num_ch*num_ch];  // host side copy.
    logic signed [data_w-1:0] active [num_ch*num_ch];  // copy seen by the multiplier.

    // host writes land in the shadow bank only.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_ch * num_ch; i++) begin
                shadow[i] <= '0;
            end
        end else if (coef_wr) begin
            shadow[coef_idx] <= coef_data;
        end
    end

    // commit copies the whole matrix in one edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_ch * num_ch; i++) begin
                active[i] <= '0;
            end
        end else if (coef_commit) begin
            for (int i = 0; i < num_ch * num_ch; i++) begin
                active[i] <= shadow[i];
            end
        end
    end

    // row major unpacking of the active bank.
    assign v00 = active[0];
    assign v01 = active[1];
    assign v02 = active[2];
    assign v03 = active[3];
    assign v10 = active[4];
    assign v11 = active[5];
    assign v12 = active[6];
    assign v13 = active[7];
    assign v20 = active[8];
    assign v21 = active[9];
    assign v22 = active[10];
    assign v23 = active[11];
    assign v30 = active[12];
    assign v31 = active[13];
    assign v32 = active[14];
    assign v33 = active[15];

endmodule

`default_nettype wire

/* ica_pkg.sv */
`default_nettype none

package ica_pkg;

    // ************************************************************************
    // datapath widths.
    // ************************************************************************

    localparam int data_w = 26;          // sample, coefficient and result width.
    localparam int frac_w = 13;          // q13 fraction bits.
    localparam int prod_w = 2 * data_w;  // one full product.
    localparam int acc_w  = prod_w + 2;  // four products summed, no overflow.

    // saturation limits of the signed result.
    localparam logic signed [data_w-1:0] z_max = {1'b0, {(data_w-1){1'b1}}};
    localparam logic signed [data_w-1:0] z_min = {1'b1, {(data_w-1){1'b0}}};

    // ************************************************************************
    // matrix and block geometry.
    // ************************************************************************

    localparam int num_ch = 4;           // channels per sample.
    localparam int idx_w  = 4;           // coefficient index, row * 4 + column.
    localparam int len_w  = 16;          // block length in samples.

    // depth of the multiplier pipeline.
    localparam int drain_cycles = 2;

    // ************************************************************************
    // block fsm encoding.
    // ************************************************************************

    localparam int state_w = 2;

    localparam logic [state_w-1:0] st_idle  = 2'd0;  // waiting for start.
    localparam logic [state_w-1:0] st_run   = 2'd1;  // accepting samples.
    localparam logic [state_w-1:0] st_drain = 2'd2;  // last results in flight.

endpackage

`default_nettype wire
